// File: src/axi_route_pkg.sv
`default_nettype none

package axi_route_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int ID_W       = 4;
  localparam int LEN_W      = 4;
  localparam int SIZE_W     = 3;
  localparam int STRB_W     = DATA_W / 8;
  localparam int NUM_SLAVES = 6;

  typedef logic [$clog2(NUM_SLAVES)-1:0] slave_idx_t;
  typedef logic [NUM_SLAVES-1:0]         slave_vec_t;

  // shared by aw and ar
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [SIZE_W-1:0] size;
    logic [1:0]        burst;
  } addr_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_chan_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } b_chan_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    logic              last;
  } r_chan_t;

  // inclusive ranges, index is the slave number
  localparam logic [ADDR_W-1:0] SLAVE_BASE [NUM_SLAVES] = '{
    32'h0000_0000, 32'h0001_0000, 32'h0002_0000,
    32'h1000_0000, 32'h2000_0000, 32'h3000_0000
  };

  localparam logic [ADDR_W-1:0] SLAVE_LIMIT [NUM_SLAVES] = '{
    32'h0000_3FFF, 32'h0001_FFFF, 32'h0002_FFFF,
    32'h1000_03FF, 32'h207F_FFFF, 32'h3000_FFFF
  };

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_phase_t;

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_phase_t;

endpackage

`default_nettype wire

// File: src/route_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module route_ctrl import axi_route_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       aw_valid,
  input  logic       aw_ready,
  input  slave_idx_t aw_hit_idx,
  input  logic       w_valid,
  input  logic       w_ready,
  input  logic       w_last,
  input  logic       b_valid,
  input  logic       b_ready,
  input  logic       ar_valid,
  input  logic       ar_ready,
  input  slave_idx_t ar_hit_idx,
  input  logic       r_valid,
  input  logic       r_ready,
  input  logic       r_last,
  output logic       aw_enable,
  output logic       ar_enable,
  output slave_idx_t wr_sel,
  output wr_phase_t  wr_phase,
  output slave_idx_t rd_sel,
  output rd_phase_t  rd_phase
);

  // one write open at a time
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_phase <= WR_IDLE;
      wr_sel   <= '0;
    end else begin
      case (wr_phase)
        WR_IDLE: begin
          // aw_ready is only high on a map hit
          if (aw_valid && aw_ready) begin
            wr_sel   <= aw_hit_idx;
            wr_phase <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (w_valid && w_ready && w_last) begin
            wr_phase <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (b_valid && b_ready) begin
            wr_phase <= WR_IDLE;
          end
        end
        default: begin
          wr_phase <= WR_IDLE;
        end
      endcase
    end
  end

  // read side runs independently of the write side
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_phase <= RD_IDLE;
      rd_sel   <= '0;
    end else begin
      case (rd_phase)
        RD_IDLE: begin
          if (ar_valid && ar_ready) begin
            rd_sel   <= ar_hit_idx;
            rd_phase <= RD_DATA;
          end
        end
        default: begin
          if (r_valid && r_ready && r_last) begin
            rd_phase <= RD_IDLE;
          end
        end
      endcase
    end
  end

  assign aw_enable = (wr_phase == WR_IDLE);
  assign ar_enable = (rd_phase == RD_IDLE);

  // w beats only pass while a write burst is open
  a_w_in_data: assert property (@(posedge clk) disable iff (!rst_n)
    (w_valid && w_ready) |-> (wr_phase == WR_DATA))
    else $error("route_ctrl: w handshake outside WR_DATA");

  // target held from aw handshake through b
  a_wr_sel_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_phase != WR_IDLE) |=> $stable(wr_sel))
    else $error("route_ctrl: wr_sel changed during write");

endmodule

`default_nettype wire

// File: src/addr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module addr_decoder import axi_route_pkg::*; #(
  parameter type chan_t = addr_chan_t
) (
  input  logic       enable,
  input  chan_t      chan,
  input  logic       valid,
  input  slave_vec_t ready_s,
  output chan_t      chan_s [NUM_SLAVES],
  output slave_vec_t valid_s,
  output logic       ready,
  output slave_idx_t hit_idx
);

  logic hit;

  // map lookup, regions never overlap
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (chan.addr >= SLAVE_BASE[i] && chan.addr <= SLAVE_LIMIT[i]) begin
        hit     = 1'b1;
        hit_idx = slave_idx_t'(i);
      end
    end
  end

  // selected slave gets the request, the rest see zeros
  always_comb begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      chan_s[i] = '0;
    end
    valid_s = '0;
    ready   = 1'b0;
    // a miss is never accepted
    if (enable && hit) begin
      chan_s[hit_idx]  = chan;
      valid_s[hit_idx] = valid;
      ready            = ready_s[hit_idx];
    end
  end

  always_comb begin
    a_valid_onehot: assert ($onehot0(valid_s))
      else $error("addr_decoder: valid_s not one-hot: %b", valid_s);
  end

endmodule

`default_nettype wire

// File: src/wdata_router.sv
`timescale 1ns/1ns
`default_nettype none

module wdata_router import axi_route_pkg::*; (
  input  wr_phase_t  wr_phase,
  input  slave_idx_t wr_sel,
  input  w_chan_t    w,
  input  logic       w_valid,
  input  slave_vec_t w_ready_s,
  output w_chan_t    w_s [NUM_SLAVES],
  output slave_vec_t w_valid_s,
  output logic       w_ready
);

  always_comb begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      w_s[i] = '0;
    end
    w_valid_s = '0;
    w_ready   = 1'b0;
    // beats follow the slave latched at aw
    if (wr_phase == WR_DATA) begin
      w_s[wr_sel]       = w;
      w_valid_s[wr_sel] = w_valid;
      w_ready           = w_ready_s[wr_sel];
    end
  end

endmodule

`default_nettype wire

// File: src/resp_router.sv
`timescale 1ns/1ns
`default_nettype none

module resp_router import axi_route_pkg::*; (
  input  wr_phase_t  wr_phase,
  input  slave_idx_t wr_sel,
  input  rd_phase_t  rd_phase,
  input  slave_idx_t rd_sel,
  input  b_chan_t    b_s [NUM_SLAVES],
  input  slave_vec_t b_valid_s,
  input  logic       b_ready,
  input  r_chan_t    r_s [NUM_SLAVES],
  input  slave_vec_t r_valid_s,
  input  logic       r_ready,
  output b_chan_t    b,
  output logic       b_valid,
  output slave_vec_t b_ready_s,
  output r_chan_t    r,
  output logic       r_valid,
  output slave_vec_t r_ready_s
);

  // write response from the latched write slave
  always_comb begin
    b         = '0;
    b_valid   = 1'b0;
    b_ready_s = '0;
    if (wr_phase == WR_RESP) begin
      b                 = b_s[wr_sel];
      b_valid           = b_valid_s[wr_sel];
      b_ready_s[wr_sel] = b_ready;
    end
  end

  // read beats from the latched read slave
  always_comb begin
    r         = '0;
    r_valid   = 1'b0;
    r_ready_s = '0;
    // other slaves stay stalled, their valid is ignored
    if (rd_phase == RD_DATA) begin
      r                 = r_s[rd_sel];
      r_valid           = r_valid_s[rd_sel];
      r_ready_s[rd_sel] = r_ready;
    end
  end

endmodule

`default_nettype wire

// File: src/axi_decoder_top.sv
`timescale 1ns/1ns
`default_nettype none

module axi_decoder_top import axi_route_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  // master port
  input  addr_chan_t aw,
  input  logic       aw_valid,
  output logic       aw_ready,
  input  w_chan_t    w,
  input  logic       w_valid,
  output logic       w_ready,
  output b_chan_t    b,
  output logic       b_valid,
  input  logic       b_ready,
  input  addr_chan_t ar,
  input  logic       ar_valid,
  output logic       ar_ready,
  output r_chan_t    r,
  output logic       r_valid,
  input  logic       r_ready,
  // slave ports
  output addr_chan_t aw_s [NUM_SLAVES],
  output slave_vec_t aw_valid_s,
  input  slave_vec_t aw_ready_s,
  output w_chan_t    w_s [NUM_SLAVES],
  output slave_vec_t w_valid_s,
  input  slave_vec_t w_ready_s,
  input  b_chan_t    b_s [NUM_SLAVES],
  input  slave_vec_t b_valid_s,
  output slave_vec_t b_ready_s,
  output addr_chan_t ar_s [NUM_SLAVES],
  output slave_vec_t ar_valid_s,
  input  slave_vec_t ar_ready_s,
  input  r_chan_t    r_s [NUM_SLAVES],
  input  slave_vec_t r_valid_s,
  output slave_vec_t r_ready_s
);

  logic       aw_enable;
  logic       ar_enable;
  slave_idx_t aw_hit_idx;
  slave_idx_t ar_hit_idx;
  slave_idx_t wr_sel;
  slave_idx_t rd_sel;
  wr_phase_t  wr_phase;
  rd_phase_t  rd_phase;

  route_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .aw_valid   (aw_valid),
    .aw_ready   (aw_ready),
    .aw_hit_idx (aw_hit_idx),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .w_last     (w.last),
    .b_valid    (b_valid),
    .b_ready    (b_ready),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .ar_hit_idx (ar_hit_idx),
    .r_valid    (r_valid),
    .r_ready    (r_ready),
    .r_last     (r.last),
    .aw_enable  (aw_enable),
    .ar_enable  (ar_enable),
    .wr_sel     (wr_sel),
    .wr_phase   (wr_phase),
    .rd_sel     (rd_sel),
    .rd_phase   (rd_phase)
  );

  addr_decoder #(.chan_t(addr_chan_t)) u_aw_dec (
    .enable  (aw_enable),
    .chan    (aw),
    .valid   (aw_valid),
    .ready_s (aw_ready_s),
    .chan_s  (aw_s),
    .valid_s (aw_valid_s),
    .ready   (aw_ready),
    .hit_idx (aw_hit_idx)
  );

  addr_decoder #(.chan_t(addr_chan_t)) u_ar_dec (
    .enable  (ar_enable),
    .chan    (ar),
    .valid   (ar_valid),
    .ready_s (ar_ready_s),
    .chan_s  (ar_s),
    .valid_s (ar_valid_s),
    .ready   (ar_ready),
    .hit_idx (ar_hit_idx)
  );

  wdata_router u_wdata (
    .wr_phase  (wr_phase),
    .wr_sel    (wr_sel),
    .w         (w),
    .w_valid   (w_valid),
    .w_ready_s (w_ready_s),
    .w_s       (w_s),
    .w_valid_s (w_valid_s),
    .w_ready   (w_ready)
  );

  resp_router u_resp (
    .wr_phase  (wr_phase),
    .wr_sel    (wr_sel),
    .rd_phase  (rd_phase),
    .rd_sel    (rd_sel),
    .b_s       (b_s),
    .b_valid_s (b_valid_s),
    .b_ready   (b_ready),
    .r_s       (r_s),
    .r_valid_s (r_valid_s),
    .r_ready   (r_ready),
    .b         (b),
    .b_valid   (b_valid),
    .b_ready_s (b_ready_s),
    .r         (r),
    .r_valid   (r_valid),
    .r_ready_s (r_ready_s)
  );

endmodule

`default_nettype wire

// File: tests/tb_axi_decoder_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_axi_decoder_top import axi_route_pkg::*; ();

  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [3:0]  len;
    logic [31:0] seed;
    logic [3:0]  stall;
    logic        pair;
  } entry_t;

  localparam int NUM_ENTRIES = 16;
  // op, address, len, data seed, max stall, runs with next entry
  localparam entry_t TABLE [NUM_ENTRIES] = '{
    '{1'b1, 32'h0000_0000, 4'd3, 32'h1100_0000, 4'd2, 1'b0},
    '{1'b0, 32'h0000_3FFF, 4'd1, 32'h0,         4'd1, 1'b0},
    '{1'b0, 32'h0001_0000, 4'd2, 32'h0,         4'd3, 1'b0},
    '{1'b1, 32'h0001_FFFF, 4'd0, 32'h2200_0000, 4'd0, 1'b0},
    '{1'b1, 32'h0002_0000, 4'd4, 32'h3300_0000, 4'd3, 1'b0},
    '{1'b0, 32'h0002_FFFF, 4'd0, 32'h0,         4'd2, 1'b0},
    '{1'b0, 32'h1000_0000, 4'd3, 32'h0,         4'd0, 1'b0},
    '{1'b1, 32'h1000_03FF, 4'd1, 32'h4400_0000, 4'd1, 1'b0},
    '{1'b1, 32'h2000_0000, 4'd7, 32'h5500_0000, 4'd2, 1'b0},
    '{1'b0, 32'h207F_FFFF, 4'd2, 32'h0,         4'd3, 1'b0},
    '{1'b0, 32'h3000_0000, 4'd1, 32'h0,         4'd1, 1'b0},
    '{1'b1, 32'h3000_FFFF, 4'd2, 32'h6600_0000, 4'd2, 1'b0},
    '{1'b1, 32'h0000_4000, 4'd0, 32'h0,         4'd0, 1'b0},
    '{1'b0, 32'h4000_0000, 4'd0, 32'h0,         4'd0, 1'b0},
    '{1'b1, 32'h0001_0040, 4'd5, 32'h7700_0000, 4'd2, 1'b1},
    '{1'b0, 32'h2000_1000, 4'd3, 32'h0,         4'd2, 1'b0}
  };

  logic       clk = 1'b0;
  logic       rst_n;
  addr_chan_t aw, ar;
  w_chan_t    w;
  b_chan_t    b;
  r_chan_t    r;
  logic       aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic       ar_valid, ar_ready, r_valid, r_ready;
  addr_chan_t aw_s [NUM_SLAVES];
  addr_chan_t ar_s [NUM_SLAVES];
  w_chan_t    w_s [NUM_SLAVES];
  b_chan_t    b_s [NUM_SLAVES];
  r_chan_t    r_s [NUM_SLAVES];
  slave_vec_t aw_valid_s, aw_ready_s, w_valid_s, w_ready_s, b_valid_s, b_ready_s;
  slave_vec_t ar_valid_s, ar_ready_s, r_valid_s, r_ready_s;

  // testbench view of the transaction state
  int         wr_state;
  int         rd_busy;
  int         wr_slave;
  int         rd_slave;
  int         cur_stall;
  int         errors;
  int         cycles;
  int         limit;
  logic [32:0] w_got [NUM_SLAVES][$];

  axi_decoder_top u_dut (.*);

  always #20 clk = ~clk;

  function automatic logic [3:0] expect_slave(logic [31:0] a);
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (a >= SLAVE_BASE[i] && a <= SLAVE_LIMIT[i]) begin
        return {1'b1, 3'(i)};
      end
    end
    return 4'h0;
  endfunction

  // new random stall after a handshake, else count down
  function automatic int next_stall(logic hs, int cnt, int max_stall);
    if (hs) begin
      return int'($urandom % (max_stall + 1));
    end
    return (cnt > 0) ? cnt - 1 : 0;
  endfunction

  task automatic check(string name, logic [63:0] exp, logic [63:0] act);
    assert (exp === act)
    else begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // slave models with bounded random stalls per handshake
  initial begin
    int aw_cnt [NUM_SLAVES];
    int w_cnt [NUM_SLAVES];
    int b_cnt [NUM_SLAVES];
    int ar_cnt [NUM_SLAVES];
    int r_cnt [NUM_SLAVES];
    int r_left [NUM_SLAVES];
    int max_stall;
    logic [31:0] r_addr [NUM_SLAVES];
    logic b_pend [NUM_SLAVES];
    slave_vec_t aw_hs, w_hs, b_hs, ar_hs, r_hs;
    void'($urandom(32'heb40));
    aw_ready_s = '0;
    w_ready_s  = '0;
    b_valid_s  = '0;
    ar_ready_s = '0;
    r_valid_s  = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      b_s[i]    = '0;
      r_s[i]    = '0;
      aw_cnt[i] = 0;
      w_cnt[i]  = 0;
      b_cnt[i]  = 0;
      ar_cnt[i] = 0;
      r_cnt[i]  = 0;
      r_left[i] = 0;
      r_addr[i] = '0;
      b_pend[i] = 1'b0;
    end
    forever begin
      @(negedge clk);
      max_stall = cur_stall;
      aw_hs = aw_valid_s & aw_ready_s;
      w_hs  = w_valid_s & w_ready_s;
      b_hs  = b_valid_s & b_ready_s;
      ar_hs = ar_valid_s & ar_ready_s;
      r_hs  = r_valid_s & r_ready_s;
      for (int i = 0; i < NUM_SLAVES; i++) begin
        if (w_hs[i]) begin
          w_got[i].push_back({w_s[i].last, w_s[i].data});
          if (w_s[i].last) b_pend[i] = 1'b1;
        end
        if (ar_hs[i]) begin
          r_addr[i] = ar_s[i].addr;
          r_left[i] = int'(ar_s[i].len) + 1;
        end
      end
      @(posedge clk);
      #2;
      for (int i = 0; i < NUM_SLAVES; i++) begin
        if (b_hs[i]) b_pend[i] = 1'b0;
        if (r_hs[i]) r_left[i]--;
        aw_cnt[i] = next_stall(aw_hs[i], aw_cnt[i], max_stall);
        w_cnt[i]  = next_stall(w_hs[i], w_cnt[i], max_stall);
        b_cnt[i]  = next_stall(b_hs[i], b_cnt[i], max_stall);
        ar_cnt[i] = next_stall(ar_hs[i], ar_cnt[i], max_stall);
        r_cnt[i]  = next_stall(r_hs[i], r_cnt[i], max_stall);
        aw_ready_s[i] = (aw_cnt[i] == 0);
        w_ready_s[i]  = (w_cnt[i] == 0);
        ar_ready_s[i] = (ar_cnt[i] == 0);
        b_valid_s[i]  = b_pend[i] && (b_cnt[i] == 0);
        b_s[i]        = '{id: 4'(i), resp: 2'b00};
        r_valid_s[i]  = (r_left[i] > 0) && (r_cnt[i] == 0);
        r_s[i]        = '{id: 4'(i), data: r_addr[i] ^ 32'(i), resp: 2'b00,
                          last: (r_left[i] == 1)};
      end
    end
  end

  // routing checks while all signals are settled
  always @(negedge clk) begin : monitor
    logic [3:0] awm;
    logic [3:0] arm;
    logic sel;
    awm = expect_slave(aw.addr);
    arm = expect_slave(ar.addr);
    if (rst_n) begin
      check("aw_ready", (wr_state == 0 && awm[3]) ? aw_ready_s[awm[2:0]] : 1'b0, aw_ready);
      check("ar_ready", (rd_busy == 0 && arm[3]) ? ar_ready_s[arm[2:0]] : 1'b0, ar_ready);
      check("w_ready", (wr_state == 1) ? w_ready_s[wr_slave] : 1'b0, w_ready);
      check("b_valid", (wr_state == 2) ? b_valid_s[wr_slave] : 1'b0, b_valid);
      check("r_valid", (rd_busy != 0) ? r_valid_s[rd_slave] : 1'b0, r_valid);
      for (int i = 0; i < NUM_SLAVES; i++) begin
        sel = (wr_state == 0) && awm[3] && (awm[2:0] == i);
        check($sformatf("aw_valid_s[%0d]", i), sel && aw_valid, aw_valid_s[i]);
        check($sformatf("aw_s[%0d]", i), sel ? aw : '0, aw_s[i]);
        sel = (rd_busy == 0) && arm[3] && (arm[2:0] == i);
        check($sformatf("ar_valid_s[%0d]", i), sel && ar_valid, ar_valid_s[i]);
        check($sformatf("ar_s[%0d]", i), sel ? ar : '0, ar_s[i]);
        sel = (wr_state == 1) && (wr_slave == i);
        check($sformatf("w_valid_s[%0d]", i), sel && w_valid, w_valid_s[i]);
        check($sformatf("w_s[%0d]", i), sel ? w : '0, w_s[i]);
        sel = (wr_state == 2) && (wr_slave == i);
        check($sformatf("b_ready_s[%0d]", i), sel && b_ready, b_ready_s[i]);
        sel = (rd_busy != 0) && (rd_slave == i);
        check($sformatf("r_ready_s[%0d]", i), sel && r_ready, r_ready_s[i]);
      end
    end
  end

  task automatic write_burst(entry_t e);
    logic [3:0] m;
    logic hs;
    logic [32:0] beat;
    m = expect_slave(e.addr);
    aw = '{id: e.seed[27:24], addr: e.addr, len: e.len, size: 3'd2, burst: 2'b01};
    aw_valid = 1'b1;
    if (!m[3]) begin
      // unmapped: never accepted, then withdrawn
      repeat (8) begin
        @(negedge clk);
        assert (!aw_ready) else begin
          $display("[ERROR] %0t aw_ready expected 0 actual 1", $time);
          errors++;
        end
        @(posedge clk);
        #2;
      end
      aw_valid = 1'b0;
      return;
    end
    wr_slave = m[2:0];
    do begin
      @(negedge clk);
      hs = aw_ready;
      @(posedge clk);
      #2;
    end while (!hs);
    wr_state = 1;
    aw_valid = 1'b0;
    aw.addr  = ~e.addr;
    for (int k = 0; k <= e.len; k++) begin
      w = '{data: e.seed + 32'(k) * 32'h0101_0101, strb: 4'hF, last: (k == e.len)};
      w_valid = 1'b1;
      do begin
        @(negedge clk);
        hs = w_ready;
        @(posedge clk);
        #2;
      end while (!hs);
    end
    w_valid  = 1'b0;
    w        = '0;
    wr_state = 2;
    // master holds off the response for one cycle
    @(posedge clk);
    #2;
    b_ready  = 1'b1;
    do begin
      @(negedge clk);
      hs = b_valid;
      if (hs) begin
        check("b.id", 4'(wr_slave), b.id);
        check("b.resp", 2'b00, b.resp);
      end
      @(posedge clk);
      #2;
    end while (!hs);
    b_ready  = 1'b0;
    wr_state = 0;
    check("w beat count", int'(e.len) + 1, w_got[wr_slave].size());
    for (int k = 0; k <= e.len; k++) begin
      beat = w_got[wr_slave].pop_front();
      check("w_s.data", e.seed + 32'(k) * 32'h0101_0101, beat[31:0]);
      check("w_s.last", (k == e.len), beat[32]);
    end
    w_got[wr_slave].delete();
  endtask

  task automatic read_burst(entry_t e);
    logic [3:0] m;
    logic hs;
    int n;
    m = expect_slave(e.addr);
    ar = '{id: 4'hA, addr: e.addr, len: e.len, size: 3'd2, burst: 2'b01};
    ar_valid = 1'b1;
    if (!m[3]) begin
      repeat (8) begin
        @(negedge clk);
        assert (!ar_ready) else begin
          $display("[ERROR] %0t ar_ready expected 0 actual 1", $time);
          errors++;
        end
        @(posedge clk);
        #2;
      end
      ar_valid = 1'b0;
      return;
    end
    rd_slave = m[2:0];
    do begin
      @(negedge clk);
      hs = ar_ready;
      @(posedge clk);
      #2;
    end while (!hs);
    rd_busy  = 1;
    ar_valid = 1'b0;
    ar.addr  = ~e.addr;
    // master holds off the first beat for one cycle
    @(posedge clk);
    #2;
    r_ready  = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      hs = r_valid && r.last;
      if (r_valid) begin
        check("r.id", 4'(rd_slave), r.id);
        check("r.data", e.addr ^ 32'(rd_slave), r.data);
        check("r.resp", 2'b00, r.resp);
        check("r.last", (n == e.len), r.last);
        n++;
      end
      @(posedge clk);
      #2;
    end while (!hs && n <= e.len);
    check("r beat count", int'(e.len) + 1, n);
    r_ready = 1'b0;
    rd_busy = 0;
  endtask

  task automatic apply_entry(entry_t e);
    if (e.wr) write_burst(e);
    else read_burst(e);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, a handshake never completed", cycles);
      $display("errors: %0d", errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    rst_n = 1'b0;
    aw = '0;
    ar = '0;
    w  = '0;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    wr_state = 0;
    rd_busy  = 0;
    wr_slave = 0;
    rd_slave = 0;
    cur_stall = 0;
    errors = 0;
    cycles = 0;
    // every beat may stall, plus setup per entry and slack
    limit = 50;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      limit += (int'(TABLE[i].len) + 1) * (int'(TABLE[i].stall) + 1) + 3;
    end
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      cur_stall = TABLE[i].stall;
      if (TABLE[i].pair && i + 1 < NUM_ENTRIES) begin
        fork
          apply_entry(TABLE[i]);
          apply_entry(TABLE[i + 1]);
        join
        i++;
      end else begin
        apply_entry(TABLE[i]);
      end
    end
    repeat (2) @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: axi_decoder_top.f
src/axi_route_pkg.sv
src/route_ctrl.sv
src/addr_decoder.sv
src/wdata_router.sv
src/resp_router.sv
src/axi_decoder_top.sv
tests/tb_axi_decoder_top.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= axi_decoder_top.f
TB_TOP    ?= tb_axi_decoder_top
RTL_TOP   ?= axi_decoder_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
